// ==== riscv_isa_pkg.sv ====
`default_nettype none

package riscv_isa_pkg;

   localparam int xlen = 32;  // instruction and immediate width

   typedef logic [4:0] reg_idx_t;
   typedef logic [2:0] funct3_t;
   typedef logic [6:0] funct7_t;

   // major opcodes, instr[6:2]
   typedef enum logic [4:0] {
      opc_load     = 5'b00000,
      opc_misc_mem = 5'b00011,
      opc_op_imm   = 5'b00100,
      opc_auipc    = 5'b00101,
      opc_store    = 5'b01000,
      opc_op       = 5'b01100,
      opc_lui      = 5'b01101,
      opc_branch   = 5'b11000,
      opc_jalr     = 5'b11001,
      opc_jal      = 5'b11011,
      opc_system   = 5'b11100
   } opcode_t;

   // branch group
   localparam funct3_t f3_beq  = 3'b000;
   localparam funct3_t f3_bne  = 3'b001;
   localparam funct3_t f3_blt  = 3'b100;
   localparam funct3_t f3_bge  = 3'b101;
   localparam funct3_t f3_bltu = 3'b110;
   localparam funct3_t f3_bgeu = 3'b111;

   // register-register group, also the muldiv selector
   localparam funct3_t f3_add_sub = 3'b000;
   localparam funct3_t f3_sll     = 3'b001;
   localparam funct3_t f3_slt     = 3'b010;
   localparam funct3_t f3_sltu    = 3'b011;
   localparam funct3_t f3_xor     = 3'b100;
   localparam funct3_t f3_srl_sra = 3'b101;
   localparam funct3_t f3_or      = 3'b110;
   localparam funct3_t f3_and     = 3'b111;

   // register-immediate group
   localparam funct3_t f3_addi      = 3'b000;
   localparam funct3_t f3_slli      = 3'b001;
   localparam funct3_t f3_slti      = 3'b010;
   localparam funct3_t f3_sltiu     = 3'b011;
   localparam funct3_t f3_xori      = 3'b100;
   localparam funct3_t f3_srli_srai = 3'b101;
   localparam funct3_t f3_ori       = 3'b110;
   localparam funct3_t f3_andi      = 3'b111;

   localparam funct7_t funct7_alt    = 7'b0100000;  // sub, sra
   localparam funct7_t funct7_muldiv = 7'b0000001;  // M extension

   // compressed quadrants, instr[1:0]
   localparam logic [1:0] c_opc_c0 = 2'b00;
   localparam logic [1:0] c_opc_c1 = 2'b01;
   localparam logic [1:0] c_opc_c2 = 2'b10;

   localparam funct3_t c2_f3_jr   = 3'b100;  // jr/mv/ebreak/jalr/add
   localparam funct3_t c2_f3_swsp = 3'b110;

   typedef struct packed {
      opcode_t    opcode;
      funct3_t    funct3;
      funct7_t    funct7;
      reg_idx_t   rs1;
      reg_idx_t   rs2;
      reg_idx_t   rd;
      logic [1:0] c_op;
      funct3_t    c_funct3;     // instr[15:13]
      logic       compressed;   // low bits not 2'b11
      logic       bit12;        // splits the c2 jr group
   } instr_fields_t;

endpackage

`default_nettype wire

// ==== decode_ctrl_pkg.sv ====
`default_nettype none

package decode_ctrl_pkg;

   typedef enum logic [4:0] {
      alu_add    = 5'd0,
      alu_sub    = 5'd1,
      alu_sll    = 5'd2,
      alu_slt    = 5'd3,
      alu_sltu   = 5'd4,
      alu_xor    = 5'd5,
      alu_srl    = 5'd6,
      alu_sra    = 5'd7,
      alu_or     = 5'd8,
      alu_and    = 5'd9,
      alu_mul    = 5'd10,
      alu_mulh   = 5'd11,
      alu_mulhsu = 5'd12,
      alu_mulhu  = 5'd13,
      alu_div    = 5'd14,
      alu_divu   = 5'd15,
      alu_rem    = 5'd16,
      alu_remu   = 5'd17
   } alu_op_t;

   typedef enum logic {s1_regval1 = 1'b0, s1_pc = 1'b1} alu_s1_sel_t;
   typedef enum logic [1:0] {s2_regval2 = 2'd0, s2_imm = 2'd1} alu_s2_sel_t;
   typedef enum logic [1:0] {reg_in_alu = 2'd0, reg_in_imm = 2'd1} reg_input_sel_t;

   // stage the execute FSM moves to next
   typedef enum logic [2:0] {
      to_fetch  = 3'd0,
      to_load   = 3'd1,
      to_store  = 3'd2,
      to_branch = 3'd3,
      to_system = 3'd4,
      to_trap   = 3'd5,
      to_dead   = 3'd6
   } exec_stage_t;

   typedef logic [5:0] branch_mask_t;  // beq bne blt bge bltu bgeu, bit 0 first

   typedef struct packed {
      alu_op_t        alu_op;
      alu_s1_sel_t    s1_sel;
      alu_s2_sel_t    s2_sel;
      reg_input_sel_t reg_input_sel;
      exec_stage_t    next_stage;
      logic           wb_from_alu;
      logic           wb_from_imm;
      logic           next_pc_from_alu;
      logic           write_reg;
      branch_mask_t   branch_mask;
   } exec_ctrl_t;

   typedef struct packed {
      riscv_isa_pkg::reg_idx_t                rs1;
      riscv_isa_pkg::reg_idx_t                rs2;
      riscv_isa_pkg::reg_idx_t                rd;
      logic [riscv_isa_pkg::xlen-1:0]         imm;
      riscv_isa_pkg::funct3_t                 funct3;
      exec_ctrl_t                             ctrl;
   } decode_out_t;

endpackage

`default_nettype wire

// ==== instr_fields.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_fields (
   input  wire [riscv_isa_pkg::xlen-1:0] i_instr,
   output riscv_isa_pkg::instr_fields_t  o_fields
);
   import riscv_isa_pkg::*;

   logic is_c;  // 16-bit encoding

   assign is_c = (i_instr[1:0] != 2'b11);

   // plain slices, valid for 32-bit words
   assign o_fields.opcode   = opcode_t'(i_instr[6:2]);
   assign o_fields.funct3   = i_instr[14:12];
   assign o_fields.funct7   = i_instr[31:25];

   // register indices move for compressed words
   // rs1 and rd share instr[11:7] in the CR format
   assign o_fields.rs1 = is_c ? i_instr[11:7] : i_instr[19:15];
   assign o_fields.rs2 = is_c ? i_instr[6:2]  : i_instr[24:20];
   assign o_fields.rd  = i_instr[11:7];  // same place in both

   assign o_fields.c_op       = i_instr[1:0];   // quadrant
   assign o_fields.c_funct3   = i_instr[15:13];
   assign o_fields.compressed = is_c;
   assign o_fields.bit12      = i_instr[12];    // add/jalr/ebreak vs mv/jr

endmodule

`default_nettype wire

// ==== imm_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module imm_gen (
   input  wire [riscv_isa_pkg::xlen-1:0] i_instr,
   input  wire riscv_isa_pkg::opcode_t   i_opcode,
   output logic [riscv_isa_pkg::xlen-1:0] o_imm
);
   import riscv_isa_pkg::*;

   // format chosen by opcode, sign always from bit 31
   always_comb begin
      case (i_opcode)
         opc_store:
            o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};  // S
         opc_branch:
            o_imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                     i_instr[11:8], 1'b0};                              // B, halfword aligned
         opc_lui, opc_auipc:
            o_imm = {i_instr[31:12], 12'b0};                            // U
         opc_jal:
            o_imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                     i_instr[30:21], 1'b0};                             // J
         default:
            o_imm = {{20{i_instr[31]}}, i_instr[31:20]};  // I, meaningless for R
      endcase
   end

endmodule

`default_nettype wire

// ==== alu_op_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_op_decode (
   input  wire riscv_isa_pkg::instr_fields_t i_fields,
   output decode_ctrl_pkg::alu_op_t          o_alu_op
);
   import riscv_isa_pkg::*;
   import decode_ctrl_pkg::*;

   logic alt;     // sub / sra
   logic muldiv;  // M extension row

   assign alt    = (i_fields.funct7 == funct7_alt);
   assign muldiv = (i_fields.funct7 == funct7_muldiv);

   always_comb begin
      o_alu_op = alu_add;  // address calc and everything else
      case (i_fields.opcode)
         opc_op: begin
            case (i_fields.funct3)
               f3_add_sub: o_alu_op = muldiv ? alu_mul : (alt ? alu_sub : alu_add);
               f3_sll:     o_alu_op = muldiv ? alu_mulh   : alu_sll;
               f3_slt:     o_alu_op = muldiv ? alu_mulhsu : alu_slt;
               f3_sltu:    o_alu_op = muldiv ? alu_mulhu  : alu_sltu;
               f3_xor:     o_alu_op = muldiv ? alu_div    : alu_xor;
               f3_srl_sra: o_alu_op = muldiv ? alu_divu : (alt ? alu_sra : alu_srl);
               f3_or:      o_alu_op = muldiv ? alu_rem    : alu_or;
               f3_and:     o_alu_op = muldiv ? alu_remu   : alu_and;
               default:    o_alu_op = alu_add;
            endcase
         end
         opc_op_imm: begin
            case (i_fields.funct3)
               f3_addi:      o_alu_op = alu_add;
               f3_slli:      o_alu_op = alu_sll;
               f3_slti:      o_alu_op = alu_slt;
               f3_sltiu:     o_alu_op = alu_sltu;
               f3_xori:      o_alu_op = alu_xor;
               f3_srli_srai: o_alu_op = i_fields.funct7[5] ? alu_sra : alu_srl;  // imm[10]
               f3_ori:       o_alu_op = alu_or;
               f3_andi:      o_alu_op = alu_and;
               default:      o_alu_op = alu_add;
            endcase
         end
         default: o_alu_op = alu_add;
      endcase
   end

endmodule

`default_nettype wire

// ==== exec_ctrl_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_ctrl_decode (
   input  wire riscv_isa_pkg::instr_fields_t i_fields,
   input  wire decode_ctrl_pkg::alu_op_t     i_alu_op,
   output decode_ctrl_pkg::exec_ctrl_t       o_ctrl,
   output riscv_isa_pkg::reg_idx_t           o_rs1
);
   import riscv_isa_pkg::*;
   import decode_ctrl_pkg::*;

   branch_mask_t mask;

   // one-hot compare select for branch words
   always_comb begin
      mask = '0;
      if (i_fields.opcode == opc_branch) begin
         case (i_fields.funct3)
            f3_beq:  mask[0] = 1'b1;
            f3_bne:  mask[1] = 1'b1;
            f3_blt:  mask[2] = 1'b1;
            f3_bge:  mask[3] = 1'b1;
            f3_bltu: mask[4] = 1'b1;
            f3_bgeu: mask[5] = 1'b1;
            default: mask    = '0;  // 010/011 not a branch
         endcase
      end
   end

   always_comb begin
      o_ctrl               = '0;  // flags low
      o_ctrl.alu_op        = alu_add;
      o_ctrl.s1_sel        = s1_regval1;
      o_ctrl.s2_sel        = s2_regval2;
      o_ctrl.reg_input_sel = reg_in_alu;
      o_ctrl.next_stage    = to_dead;
      o_ctrl.branch_mask   = mask;
      o_rs1                = i_fields.rs1;

      if (!i_fields.compressed) begin
         case (i_fields.opcode)
            opc_op, opc_op_imm: begin
               o_ctrl.alu_op      = i_alu_op;
               o_ctrl.s2_sel      = (i_fields.opcode == opc_op) ? s2_regval2 : s2_imm;
               o_ctrl.wb_from_alu = 1'b1;  // writeback happens in fetch
               o_ctrl.next_stage  = to_fetch;
            end
            opc_load, opc_store: begin
               o_ctrl.s2_sel     = s2_imm;  // rs1 + offset
               o_ctrl.next_stage = (i_fields.opcode == opc_load) ? to_load : to_store;
            end
            opc_jal, opc_jalr: begin
               o_ctrl.write_reg        = 1'b1;  // link address
               o_ctrl.reg_input_sel    = reg_in_alu;
               o_ctrl.s1_sel           = (i_fields.opcode == opc_jal) ? s1_pc : s1_regval1;
               o_ctrl.s2_sel           = s2_imm;
               o_ctrl.next_pc_from_alu = 1'b1;
               o_ctrl.next_stage       = to_fetch;
            end
            opc_branch: o_ctrl.next_stage = to_branch;  // regval1 vs regval2
            opc_auipc: begin
               o_ctrl.s1_sel      = s1_pc;   // pc + imm
               o_ctrl.s2_sel      = s2_imm;
               o_ctrl.wb_from_alu = 1'b1;
               o_ctrl.next_stage  = to_fetch;
            end
            opc_lui: begin
               o_ctrl.wb_from_imm   = 1'b1;
               o_ctrl.reg_input_sel = reg_in_imm;
               o_ctrl.next_stage    = to_fetch;
            end
            opc_misc_mem: o_ctrl.next_stage = to_fetch;  // fence is a nop here
            opc_system:   o_ctrl.next_stage = to_system;
            default:      o_ctrl.next_stage = to_trap;   // illegal opcode
         endcase
      end else begin
         case (i_fields.c_op)
            c_opc_c0: o_ctrl.next_stage = to_dead;   // no c0 support
            c_opc_c1: o_ctrl.next_stage = to_fetch;  // executes as nop
            c_opc_c2: begin
               case (i_fields.c_funct3)
                  c2_f3_jr: begin
                     if (i_fields.bit12) begin
                        // c.add needs rs2 and rd nonzero
                        if (i_fields.rs2 != '0 && i_fields.rd != '0) begin
                           o_ctrl.wb_from_alu = 1'b1;
                           o_ctrl.next_stage  = to_fetch;
                        end
                     end else if (i_fields.rs2 == '0) begin
                        if (i_fields.rs1 != '0) begin  // c.jr needs rs1 nonzero
                           o_ctrl.write_reg        = 1'b1;
                           o_ctrl.next_pc_from_alu = 1'b1;
                           o_ctrl.next_stage       = to_fetch;
                        end
                     end else begin
                        o_rs1              = '0;  // c.mv is x0 + rs2
                        o_ctrl.wb_from_alu = 1'b1;
                        o_ctrl.next_stage  = to_fetch;
                     end
                  end
                  c2_f3_swsp: o_ctrl.next_stage = to_dead;
                  default:    o_ctrl.next_stage = to_dead;  // slli, lwsp, fp forms
               endcase
            end
            default: o_ctrl.next_stage = to_dead;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== decode_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_reg (
   input  wire                             i_clk,
   input  wire                             i_arst_n,
   input  wire decode_ctrl_pkg::decode_out_t i_dec,
   input  wire                             i_valid,
   output logic                            o_ready,
   output decode_ctrl_pkg::decode_out_t    o_dec,
   output logic                            o_valid,
   input  wire                             i_ready
);
   logic full;
   logic load;

   assign o_ready = !full || i_ready;  // free now or draining this cycle
   assign load    = i_valid && o_ready;
   assign o_valid = full;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         full <= 1'b0;
      end else if (load) begin
         full <= 1'b1;  // refill, also back to back
      end else if (i_ready) begin
         full <= 1'b0;  // taken, nothing new
      end
   end

   // payload only
   always_ff @(posedge i_clk) begin
      if (load) begin
         o_dec <= i_dec;
      end
   end

endmodule

`default_nettype wire

// ==== rv_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_decoder (
   input  wire                           i_clk,
   input  wire                           i_arst_n,
   input  wire [riscv_isa_pkg::xlen-1:0] i_instr,
   input  wire                           i_valid,
   output logic                          o_ready,
   output decode_ctrl_pkg::decode_out_t  o_dec,
   output logic                          o_valid,
   input  wire                           i_ready
);
   import riscv_isa_pkg::*;
   import decode_ctrl_pkg::*;

   instr_fields_t     fields;
   logic [xlen-1:0]   imm;
   alu_op_t           alu_op;
   exec_ctrl_t        ctrl;
   reg_idx_t          rs1;    // after c.mv override
   decode_out_t       dec;

   instr_fields i_instr_fields (
      .i_instr  (i_instr),
      .o_fields (fields)
   );

   imm_gen i_imm_gen (
      .i_instr  (i_instr),
      .i_opcode (fields.opcode),
      .o_imm    (imm)
   );

   alu_op_decode i_alu_op_decode (
      .i_fields (fields),
      .o_alu_op (alu_op)
   );

   exec_ctrl_decode i_exec_ctrl_decode (
      .i_fields (fields),
      .i_alu_op (alu_op),
      .o_ctrl   (ctrl),
      .o_rs1    (rs1)
   );

   // everything the execute stage needs, in one word
   assign dec = '{rs1: rs1, rs2: fields.rs2, rd: fields.rd, imm: imm,
                  funct3: fields.funct3, ctrl: ctrl};

   decode_reg i_decode_reg (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_dec    (dec),
      .i_valid  (i_valid),
      .o_ready  (o_ready),
      .o_dec    (o_dec),
      .o_valid  (o_valid),
      .i_ready  (i_ready)
   );

endmodule

`default_nettype wire

// ==== rv_decoder_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_decoder_asserts (
   input wire                               i_clk,
   input wire                               i_arst_n,
   input wire                               i_valid,
   input wire decode_ctrl_pkg::decode_out_t i_dec,
   input wire                               i_ready,
   input wire                               o_ready,
   input wire                               o_valid,
   input wire decode_ctrl_pkg::decode_out_t o_dec
);

   // full flag cleared while reset is held
   a_no_valid_in_reset: assert property (@(posedge i_clk) !i_arst_n |-> !o_valid)
      else $error("o_valid high during reset");

   // stalled result must not move
   a_hold_on_stall: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (o_valid && !i_ready) |=> (o_valid && $stable(o_dec)))
      else $error("o_dec changed or dropped while stalled");

   // accepted word shows one cycle later
   a_load_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (i_valid && o_ready) |=> (o_valid && o_dec == $past(i_dec)))
      else $error("accepted word not in the register one cycle later");

endmodule

bind decode_reg rv_decoder_asserts i_rv_decoder_asserts (
   .i_clk    (i_clk),
   .i_arst_n (i_arst_n),
   .i_valid  (i_valid),
   .i_dec    (i_dec),
   .i_ready  (i_ready),
   .o_ready  (o_ready),
   .o_valid  (o_valid),
   .o_dec    (o_dec)
);

`default_nettype wire

// ==== tb_rv_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_decoder;
   import riscv_isa_pkg::*;
   import decode_ctrl_pkg::*;

   localparam int max_tests = 64;  // room in the vector tables

   logic            i_clk;
   logic            i_arst_n;
   logic [xlen-1:0] i_instr;
   logic            i_valid;
   logic            o_ready;
   decode_out_t     o_dec;
   logic            o_valid;
   logic            i_ready;

   logic [xlen-1:0] instr_tab [max_tests];
   decode_out_t     exp_tab [max_tests];
   int              pend_q [$];  // line numbers accepted but not yet seen at the output

   int n_tests;
   int n_recv;        // output handshakes
   int n_pass;
   int n_err;
   int mismatches;    // within the current result
   int cycles;
   int cycle_limit;

   rv_decoder i_rv_decoder (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_instr  (i_instr),
      .i_valid  (i_valid),
      .o_ready  (o_ready),
      .o_dec    (o_dec),
      .o_valid  (o_valid),
      .i_ready  (i_ready)
   );

   always #20 i_clk = ~i_clk;  // 40 ns period

   always @(posedge i_clk) cycles <= cycles + 1;

   // consumer stalls about one cycle in four
   always @(posedge i_clk) begin
      #2 i_ready = ($urandom % 4) != 0;
   end

   task automatic check_regs(input string name, input reg_idx_t got, input reg_idx_t exp,
                             input int idx);
      if (got !== exp) begin
         $display("CHECK FAILED %s got %h expected %h (test %0d)", name, got, exp, idx);
         mismatches++;
         n_err++;
      end
   endtask

   task automatic check_imm(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                            input int idx);
      if (got !== exp) begin
         $display("CHECK FAILED o_dec.imm got %h expected %h (test %0d)", got, exp, idx);
         mismatches++;
         n_err++;
      end
   endtask

   task automatic check_funct3(input funct3_t got, input funct3_t exp, input int idx);
      if (got !== exp) begin
         $display("CHECK FAILED o_dec.funct3 got %h expected %h (test %0d)", got, exp, idx);
         mismatches++;
         n_err++;
      end
   endtask

   task automatic check_ctrl(input exec_ctrl_t got, input exec_ctrl_t exp, input int idx);
      if (got !== exp) begin
         $display("CHECK FAILED o_dec.ctrl got %h expected %h (test %0d)", got, exp, idx);
         mismatches++;
         n_err++;
      end
   endtask

   // reads one vector per line and skips '#' lines
   task automatic load_vectors();
      int          fd;
      int          rc;
      string       line;
      logic [31:0] col [16];
      decode_out_t exp;
      fd = $fopen("decode_input.txt", "r");
      if (fd == 0) begin
         $display("cannot open decode_input.txt");
         n_err++;
      end else begin
         while (!$feof(fd) && n_tests < max_tests) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc == 0 || line.len() < 2 || line[0] == "#") continue;
            rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                         col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15]);
            if (rc != 16) begin
               $display("malformed line in decode_input.txt: %s", line);
               n_err++;
               continue;
            end
            exp.rs1                   = col[1][4:0];
            exp.rs2                   = col[2][4:0];
            exp.rd                    = col[3][4:0];
            exp.imm                   = col[4];
            exp.funct3                = col[5][2:0];
            exp.ctrl.alu_op           = alu_op_t'(col[6][4:0]);
            exp.ctrl.s1_sel           = alu_s1_sel_t'(col[7][0]);
            exp.ctrl.s2_sel           = alu_s2_sel_t'(col[8][1:0]);
            exp.ctrl.reg_input_sel    = reg_input_sel_t'(col[9][1:0]);
            exp.ctrl.next_stage       = exec_stage_t'(col[10][2:0]);
            exp.ctrl.wb_from_alu      = col[11][0];
            exp.ctrl.wb_from_imm      = col[12][0];
            exp.ctrl.next_pc_from_alu = col[13][0];
            exp.ctrl.write_reg        = col[14][0];
            exp.ctrl.branch_mask      = col[15][5:0];
            instr_tab[n_tests] = col[0];
            exp_tab[n_tests]   = exp;
            n_tests++;
         end
         $fclose(fd);
      end
   endtask

   // o_ready settles mid-cycle and holds until the next edge
   task automatic wait_accept();
      @(negedge i_clk);
      while (!o_ready) @(negedge i_clk);
   endtask

   task automatic check_result();
      int idx;
      decode_out_t exp;
      n_recv++;
      if (pend_q.size() == 0) begin
         $display("output handshake with no accepted input behind it");
         n_err++;
      end else begin
         idx = pend_q.pop_front();  // oldest first so order is kept
         exp = exp_tab[idx];
         mismatches = 0;
         check_regs("o_dec.rs1", o_dec.rs1, exp.rs1, idx);
         check_regs("o_dec.rs2", o_dec.rs2, exp.rs2, idx);
         check_regs("o_dec.rd", o_dec.rd, exp.rd, idx);
         check_imm(o_dec.imm, exp.imm, idx);
         check_funct3(o_dec.funct3, exp.funct3, idx);
         check_ctrl(o_dec.ctrl, exp.ctrl, idx);
         if (mismatches == 0) begin
            n_pass++;
            $display("test %0d instr %h ok", idx, instr_tab[idx]);
         end else begin
            $display("test %0d instr %h had %0d mismatches", idx, instr_tab[idx], mismatches);
         end
      end
   endtask

   // sample the output handshake mid-cycle
   always @(negedge i_clk) begin
      if (i_arst_n && o_valid && i_ready) check_result();
   end

   initial begin
      wait (cycle_limit > 0);
      wait (cycles >= cycle_limit);
      $display("timeout after %0d cycles, run hung with %0d of %0d results", cycles, n_recv,
               n_tests);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      i_clk       = 1'b0;
      i_arst_n    = 1'b0;
      i_instr     = '0;
      i_valid     = 1'b0;
      i_ready     = 1'b0;
      n_tests     = 0;
      n_recv      = 0;
      n_pass      = 0;
      n_err       = 0;
      cycles      = 0;
      cycle_limit = 0;
      void'($urandom(32'hb291_5b3d));  // one seed for the whole run
      load_vectors();
      repeat (4) @(posedge i_clk);
      #2 i_arst_n = 1'b1;
      if (n_tests == 0) begin
         $display("no test vectors read from decode_input.txt");
         n_err++;
      end else begin
         cycle_limit = 4 * n_tests + 20;
         @(posedge i_clk);
         #2;
         if (!o_ready || o_valid) begin
            $display("DUT not empty and ready right after reset");
            n_err++;
         end
         for (int t = 0; t < n_tests; t++) begin
            i_instr = instr_tab[t];
            i_valid = 1'b1;
            wait_accept();
            pend_q.push_back(t);  // taken at the coming edge
            @(posedge i_clk);
            #2;
         end
         i_valid = 1'b0;
         while (n_recv < n_tests) @(posedge i_clk);
         @(negedge i_clk);
         if (o_valid) begin
            $display("DUT still holds a result after the last one was taken");
            n_err++;
         end
         if (n_recv != n_tests || pend_q.size() != 0) begin
            $display("%0d results for %0d inputs", n_recv, n_tests);
            n_err++;
         end
      end
      $display("tests %0d, passed %0d, failed %0d, errors %0d", n_tests, n_pass,
               n_tests - n_pass, n_err);
      if (n_err == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== decode_input.txt ====
# instr rs1 rs2 rd imm funct3 | alu_op s1 s2 reg_in stage wb_alu wb_imm npc_alu wr_reg mask
# all hex; stage 0 fetch 1 load 2 store 3 branch 4 system 5 trap 6 dead
002081b3 01 02 03 00000002 0 00 0 0 0 0 1 0 0 0 00
407302b3 06 07 05 00000407 0 01 0 0 0 0 1 0 0 0 00
40c5d533 0b 0c 0a 0000040c 5 07 0 0 0 0 1 0 0 0 00
40315093 02 03 01 00000403 5 07 0 1 0 0 1 0 0 0 00
022081b3 01 02 03 00000022 0 0a 0 0 0 0 1 0 0 0 00
022091b3 01 02 03 00000022 1 0b 0 0 0 0 1 0 0 0 00
0220a1b3 01 02 03 00000022 2 0c 0 0 0 0 1 0 0 0 00
0220b1b3 01 02 03 00000022 3 0d 0 0 0 0 1 0 0 0 00
0220c1b3 01 02 03 00000022 4 0e 0 0 0 0 1 0 0 0 00
0220d1b3 01 02 03 00000022 5 0f 0 0 0 0 1 0 0 0 00
0220e1b3 01 02 03 00000022 6 10 0 0 0 0 1 0 0 0 00
0220f1b3 01 02 03 00000022 7 11 0 0 0 0 1 0 0 0 00
fe512e23 02 05 1c fffffffc 2 00 0 1 0 2 0 0 0 0 00
fe208ce3 01 02 19 fffffff8 0 00 0 0 0 3 0 0 0 0 01
00209863 01 02 10 00000010 1 00 0 0 0 3 0 0 0 0 02
0041c263 03 04 04 00000004 4 00 0 0 0 3 0 0 0 0 04
0041d263 03 04 04 00000004 5 00 0 0 0 3 0 0 0 0 08
0041e263 03 04 04 00000004 6 00 0 0 0 3 0 0 0 0 10
0041f263 03 04 04 00000004 7 00 0 0 0 3 0 0 0 0 20
123452b7 08 03 05 12345000 5 00 0 0 1 0 0 1 0 0 00
fffff317 1f 1f 06 fffff000 7 00 1 1 0 0 1 0 0 0 00
ffdff0ef 1f 1d 01 fffffffc 7 00 1 1 0 0 0 0 1 1 00
00808067 01 08 00 00000008 0 00 0 1 0 0 0 0 1 1 00
fff42383 08 1f 07 ffffffff 2 00 0 1 0 1 0 0 0 0 00
00000073 00 00 00 00000000 0 00 0 0 0 4 0 0 0 0 00
0000050b 00 00 0a 00000000 0 00 0 0 0 5 0 0 0 0 00
00009426 08 09 08 00000000 1 00 0 0 0 0 1 0 0 0 00
0000852e 00 0b 0a 00000000 0 00 0 0 0 0 1 0 0 0 00
00008082 01 00 01 00000000 0 00 0 0 0 0 0 0 1 1 00
00008002 00 00 00 00000000 0 00 0 0 0 6 0 0 0 0 00
00009002 00 00 00 00000000 1 00 0 0 0 6 0 0 0 0 00
0000c016 00 05 00 0000c000 4 00 0 0 0 6 0 0 0 0 00
00000085 01 01 01 00000000 0 00 0 0 0 0 0 0 0 0 00

// ==== vlog.f ====
riscv_isa_pkg.sv
decode_ctrl_pkg.sv
instr_fields.sv
imm_gen.sv
alu_op_decode.sv
exec_ctrl_decode.sv
decode_reg.sv
rv_decoder.sv
rv_decoder_asserts.sv
tb_rv_decoder.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run tb_rv_decoder"
	@echo "  clean  remove obj_dir and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_rv_decoder -Mdir obj_dir
	./obj_dir/Vtb_rv_decoder > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
